//--- hw/parser_pkg.sv
package parser_pkg;

// stream and header widths
localparam int AXIS_DATA_W  = 256;
localparam int AXIS_KEEP_W  = AXIS_DATA_W / 8;
localparam int AXIS_TUSER_W = 128;
localparam int NUM_SEGS     = 4;
localparam int HDR_W        = NUM_SEGS * AXIS_DATA_W;
localparam int VLAN_W       = 12;
// vlan bits [8:4] pick the table entry
localparam int VLAN_SEL_LSB = 4;

// parse action table
localparam int ACT_W      = 16;
localparam int NUM_ACTS   = 10;
localparam int NUM_CONT   = 8;
localparam int ACT_RAM_W  = NUM_ACTS * ACT_W;
localparam int ACT_RAM_AW = 5;

// action word layout, bits 15:13 reserved
localparam int ACT_VALID_BIT = 0;
localparam int ACT_IDX_LSB   = 1;
localparam int ACT_IDX_W     = 3;
localparam int ACT_TYPE_LSB  = 4;
localparam int ACT_TYPE_W    = 2;
localparam int ACT_OFF_LSB   = 6;
localparam int ACT_OFF_W     = 7;

// container type codes
localparam logic [ACT_TYPE_W-1:0] CONT_NONE = 2'd0;
localparam logic [ACT_TYPE_W-1:0] CONT_2B   = 2'd1;
localparam logic [ACT_TYPE_W-1:0] CONT_4B   = 2'd2;
localparam logic [ACT_TYPE_W-1:0] CONT_6B   = 2'd3;

localparam int CONT_2B_W = 16;
localparam int CONT_4B_W = 32;
localparam int CONT_6B_W = 48;

// control packet fields, beat 2
localparam int CTRL_MODID_LSB = 112;
localparam int CTRL_ADDR_LSB  = 128;

// phv layout, metadata at the bottom
localparam int PHV_W      = 1024;
localparam int META_W     = 256;
localparam int META_PAD_W = META_W - VLAN_W - 1 - AXIS_TUSER_W;
localparam int PHV_2B_LSB = META_W;
localparam int PHV_4B_LSB = PHV_2B_LSB + NUM_CONT * CONT_2B_W;
localparam int PHV_6B_LSB = PHV_4B_LSB + NUM_CONT * CONT_4B_W;

endpackage

//--- hw/parser_fifo.sv
`timescale 1ns/100ps

module parser_fifo #(
	parameter int WIDTH      = 8,
	parameter int DEPTH_LOG2 = 4
) (
	input  logic             axis_clk,
	input  logic             aresetn,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty,
	output logic             full
);

localparam int DEPTH = 1 << DEPTH_LOG2;

logic [WIDTH-1:0]      mem [DEPTH];
logic [DEPTH_LOG2-1:0] wr_ptr;
logic [DEPTH_LOG2-1:0] rd_ptr;
logic [DEPTH_LOG2:0]   count;
logic                  do_wr;
logic                  do_rd;

assign do_wr = wr_en && !full;
assign do_rd = rd_en && !empty;
assign empty = (count == '0);
// count tops out at DEPTH, so the msb alone means full
assign full = count[DEPTH_LOG2];

// head shown before the read strobe
assign rd_data = mem[rd_ptr];

always_ff @(posedge axis_clk) begin
	if (do_wr) begin
		mem[wr_ptr] <= wr_data;
	end
end

always_ff @(posedge axis_clk) begin
	if (!aresetn) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (do_wr) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
		if (do_rd) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
		case ({do_wr, do_rd})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

endmodule

//--- hw/parse_act_ram.sv
`timescale 1ns/100ps

module parse_act_ram
	import parser_pkg::*;
(
	input  logic                  axis_clk,
	input  logic                  wr_en,
	input  logic [ACT_RAM_AW-1:0] wr_addr,
	input  logic [ACT_RAM_W-1:0]  wr_data,
	input  logic [ACT_RAM_AW-1:0] rd_addr,
	output logic [ACT_RAM_W-1:0]  rd_data
);

logic [ACT_RAM_W-1:0] mem [1 << ACT_RAM_AW];

always_ff @(posedge axis_clk) begin
	if (wr_en) begin
		mem[wr_addr] <= wr_data;
	end
end

// one cycle read latency
always_ff @(posedge axis_clk) begin
	rd_data <= mem[rd_addr];
end

endmodule

//--- hw/sub_parser.sv
`timescale 1ns/100ps

module sub_parser
	import parser_pkg::*;
(
	input  logic                  axis_clk,
	input  logic                  aresetn,
	input  logic                  act_valid,
	input  logic [ACT_W-1:0]      act,
	input  logic [HDR_W-1:0]      hdr,
	output logic                  val_out_valid,
	output logic [CONT_6B_W-1:0]  val_out,
	output logic [ACT_TYPE_W-1:0] val_out_type,
	output logic [ACT_IDX_W-1:0]  val_out_seq
);

logic [HDR_W+CONT_6B_W-1:0] hdr_ext;
logic [ACT_OFF_W+2:0]       bit_off;

// zero bytes past the end so long offsets read zero
assign hdr_ext = {{CONT_6B_W{1'b0}}, hdr};
assign bit_off = {act[ACT_OFF_LSB +: ACT_OFF_W], 3'b000};

always_ff @(posedge axis_clk) begin
	if (!aresetn) begin
		val_out_valid <= 1'b0;
		val_out_type <= CONT_NONE;
	end else begin
		val_out_valid <= act_valid;
		if (act_valid) begin
			if (act[ACT_VALID_BIT]) begin
				val_out_type <= act[ACT_TYPE_LSB +: ACT_TYPE_W];
			end else begin
				val_out_type <= CONT_NONE;
			end
		end
	end
end

// first field byte lands in val_out[7:0]
always_ff @(posedge axis_clk) begin
	if (act_valid) begin
		val_out <= hdr_ext[bit_off +: CONT_6B_W];
		val_out_seq <= act[ACT_IDX_LSB +: ACT_IDX_W];
	end
end

endmodule

//--- hw/parse_ctrl_writer.sv
`timescale 1ns/100ps

module parse_ctrl_writer
	import parser_pkg::*;
#(
	parameter logic [2:0] PARSER_MOD_ID = 3'd0
) (
	input  logic                    axis_clk,
	input  logic                    aresetn,
	input  logic [AXIS_DATA_W-1:0]  ctrl_s_tdata,
	input  logic [AXIS_TUSER_W-1:0] ctrl_s_tuser,
	input  logic [AXIS_KEEP_W-1:0]  ctrl_s_tkeep,
	input  logic                    ctrl_s_tvalid,
	input  logic                    ctrl_s_tlast,
	output logic [AXIS_DATA_W-1:0]  ctrl_m_tdata,
	output logic [AXIS_TUSER_W-1:0] ctrl_m_tuser,
	output logic [AXIS_KEEP_W-1:0]  ctrl_m_tkeep,
	output logic                    ctrl_m_tvalid,
	output logic                    ctrl_m_tlast,
	output logic                    ram_wr_en,
	output logic [ACT_RAM_AW-1:0]   ram_wr_addr,
	output logic [ACT_RAM_W-1:0]    ram_wr_data
);

localparam logic [2:0] WAIT_FIRST  = 3'd0;
localparam logic [2:0] WAIT_SECOND = 3'd1;
localparam logic [2:0] WAIT_THIRD  = 3'd2;
localparam logic [2:0] WRITE_RAM   = 3'd3;
localparam logic [2:0] FLUSH       = 3'd4;

logic [2:0]           ctrl_state;
logic [2:0]           ctrl_state_next;
logic                 wr_en_next;
logic                 mod_match;
logic [ACT_RAM_W-1:0] entry_swapped;

assign mod_match = (ctrl_s_tdata[CTRL_MODID_LSB +: 3] == PARSER_MOD_ID);

// byte 0 of the beat becomes the top of the entry
always_comb begin
	for (int b = 0; b < ACT_RAM_W / 8; b++) begin
		entry_swapped[ACT_RAM_W - 1 - 8 * b -: 8] = ctrl_s_tdata[8 * b +: 8];
	end
end

always_comb begin
	ctrl_state_next = ctrl_state;
	wr_en_next = 1'b0;
	case (ctrl_state)
		WAIT_FIRST: begin
			if (ctrl_s_tvalid) begin
				ctrl_state_next = WAIT_SECOND;
			end
		end
		WAIT_SECOND: begin
			if (ctrl_s_tvalid) begin
				ctrl_state_next = mod_match ? WAIT_THIRD : FLUSH;
			end
		end
		WAIT_THIRD: begin
			if (ctrl_s_tvalid) begin
				ctrl_state_next = WRITE_RAM;
			end
		end
		WRITE_RAM: begin
			if (ctrl_s_tvalid) begin
				wr_en_next = 1'b1;
				ctrl_state_next = ctrl_s_tlast ? WAIT_FIRST : FLUSH;
			end
		end
		FLUSH: begin
			if (ctrl_s_tvalid && ctrl_s_tlast) begin
				ctrl_state_next = WAIT_FIRST;
			end
		end
		default: ctrl_state_next = WAIT_FIRST;
	endcase
end

// forwarding stage plus fsm
always_ff @(posedge axis_clk) begin
	if (!aresetn) begin
		ctrl_state <= WAIT_FIRST;
		ram_wr_en <= 1'b0;
		ctrl_m_tdata <= '0;
		ctrl_m_tuser <= '0;
		ctrl_m_tkeep <= '0;
		ctrl_m_tvalid <= 1'b0;
		ctrl_m_tlast <= 1'b0;
	end else begin
		ctrl_state <= ctrl_state_next;
		ram_wr_en <= wr_en_next;
		ctrl_m_tdata <= ctrl_s_tdata;
		ctrl_m_tuser <= ctrl_s_tuser;
		ctrl_m_tkeep <= ctrl_s_tkeep;
		ctrl_m_tvalid <= ctrl_s_tvalid;
		ctrl_m_tlast <= ctrl_s_tlast;
	end
end

always_ff @(posedge axis_clk) begin
	if (ctrl_state == WAIT_SECOND && ctrl_s_tvalid && mod_match) begin
		ram_wr_addr <= ctrl_s_tdata[CTRL_ADDR_LSB +: ACT_RAM_AW];
	end
	if (ctrl_state == WAIT_THIRD && ctrl_s_tvalid) begin
		ram_wr_data <= entry_swapped;
	end
end

endmodule

//--- hw/parser_do_parsing.sv
`timescale 1ns/100ps

module parser_do_parsing
	import parser_pkg::*;
(
	input  logic                    axis_clk,
	input  logic                    aresetn,
	input  logic [HDR_W-1:0]        hdr_segs,
	input  logic [AXIS_TUSER_W-1:0] tuser_1st,
	input  logic [VLAN_W-1:0]       vlan_id,
	input  logic                    segs_empty,
	input  logic                    vlan_empty,
	input  logic [ACT_RAM_W-1:0]    act_entry,
	input  logic                    stg_ready_in,
	input  logic                    out_vlan_ready,
	output logic                    segs_rd,
	output logic                    vlan_rd,
	output logic                    parser_valid,
	output logic [PHV_W-1:0]        pkt_hdr_vec,
	output logic [VLAN_W-1:0]       out_vlan,
	output logic                    out_vlan_valid
);

localparam logic [2:0] IDLE     = 3'd0;
localparam logic [2:0] WAIT_RAM = 3'd1;
localparam logic [2:0] START    = 3'd2;
localparam logic [2:0] FINISH   = 3'd3;
localparam logic [2:0] GET      = 3'd4;
localparam logic [2:0] OUTPUT   = 3'd5;

logic [2:0] state;
logic [2:0] state_next;
logic       sp_start;
logic       phv_release;
logic       vlan_pending;
logic       vlan_pending_next;
logic       out_vlan_valid_next;

logic [NUM_ACTS-1:0]   sp_valid;
logic [CONT_6B_W-1:0]  sp_val [NUM_ACTS];
logic [ACT_TYPE_W-1:0] sp_type [NUM_ACTS];
logic [ACT_IDX_W-1:0]  sp_seq [NUM_ACTS];

logic [CONT_2B_W-1:0] cont_2b [NUM_CONT];
logic [CONT_4B_W-1:0] cont_4b [NUM_CONT];
logic [CONT_6B_W-1:0] cont_6b [NUM_CONT];
logic [PHV_W-1:0]     phv_next;

always_comb begin
	state_next = state;
	sp_start = 1'b0;
	phv_release = 1'b0;
	case (state)
		IDLE: begin
			if (!vlan_empty) begin
				state_next = WAIT_RAM;
			end
		end
		WAIT_RAM: state_next = START;
		START: begin
			if (!segs_empty) begin
				sp_start = 1'b1;
				state_next = FINISH;
			end
		end
		FINISH: state_next = GET;
		GET: state_next = OUTPUT;
		OUTPUT: begin
			if (stg_ready_in) begin
				phv_release = 1'b1;
				state_next = IDLE;
			end
		end
		default: state_next = IDLE;
	endcase
end

// both fifos pop together as the phv leaves
assign segs_rd = phv_release;
assign vlan_rd = phv_release;

// vlan offered from idle until the end of start
always_comb begin
	vlan_pending_next = vlan_pending;
	out_vlan_valid_next = 1'b0;
	if (state == IDLE && !vlan_empty) begin
		vlan_pending_next = !out_vlan_ready;
		out_vlan_valid_next = out_vlan_ready;
	end else if ((state == WAIT_RAM || state == START) && vlan_pending && out_vlan_ready) begin
		vlan_pending_next = 1'b0;
		out_vlan_valid_next = 1'b1;
	end
end

always_ff @(posedge axis_clk) begin
	if (!aresetn) begin
		state <= IDLE;
		parser_valid <= 1'b0;
		out_vlan_valid <= 1'b0;
		vlan_pending <= 1'b0;
	end else begin
		state <= state_next;
		parser_valid <= phv_release;
		out_vlan_valid <= out_vlan_valid_next;
		vlan_pending <= vlan_pending_next;
	end
end

always_ff @(posedge axis_clk) begin
	if (state == IDLE && !vlan_empty) begin
		out_vlan <= vlan_id;
	end
	if (state == GET) begin
		pkt_hdr_vec <= phv_next;
	end
end

// later actions overwrite earlier ones on the same container
always_ff @(posedge axis_clk) begin
	if (!aresetn || phv_release) begin
		for (int c = 0; c < NUM_CONT; c++) begin
			cont_2b[c] <= '0;
			cont_4b[c] <= '0;
			cont_6b[c] <= '0;
		end
	end else if (state == FINISH) begin
		for (int i = 0; i < NUM_ACTS; i++) begin
			if (sp_valid[i]) begin
				case (sp_type[i])
					CONT_2B: cont_2b[sp_seq[i]] <= sp_val[i][CONT_2B_W-1:0];
					CONT_4B: cont_4b[sp_seq[i]] <= sp_val[i][CONT_4B_W-1:0];
					CONT_6B: cont_6b[sp_seq[i]] <= sp_val[i];
					default: ;
				endcase
			end
		end
	end
end

// byte swap so the first header byte is most significant
always_comb begin
	phv_next = '0;
	for (int c = 0; c < NUM_CONT; c++) begin
		for (int b = 0; b < CONT_2B_W / 8; b++) begin
			phv_next[PHV_2B_LSB + CONT_2B_W * (c + 1) - 1 - 8 * b -: 8] = cont_2b[c][8 * b +: 8];
		end
		for (int b = 0; b < CONT_4B_W / 8; b++) begin
			phv_next[PHV_4B_LSB + CONT_4B_W * (c + 1) - 1 - 8 * b -: 8] = cont_4b[c][8 * b +: 8];
		end
		for (int b = 0; b < CONT_6B_W / 8; b++) begin
			phv_next[PHV_6B_LSB + CONT_6B_W * (c + 1) - 1 - 8 * b -: 8] = cont_6b[c][8 * b +: 8];
		end
	end
	phv_next[META_W-1:0] = {{META_PAD_W{1'b0}}, vlan_id, 1'b0, tuser_1st};
end

// action 0 sits at the top of the entry
for (genvar i = 0; i < NUM_ACTS; i++) begin : g_sub
	sub_parser u_sub_parser (
		.axis_clk      (axis_clk),
		.aresetn       (aresetn),
		.act_valid     (sp_start),
		.act           (act_entry[ACT_RAM_W - ACT_W * (i + 1) +: ACT_W]),
		.hdr           (hdr_segs),
		.val_out_valid (sp_valid[i]),
		.val_out       (sp_val[i]),
		.val_out_type  (sp_type[i]),
		.val_out_seq   (sp_seq[i])
	);
end

endmodule

//--- hw/pkt_hdr_parser_top.sv
`timescale 1ns/100ps

module pkt_hdr_parser_top
	import parser_pkg::*;
#(
	parameter logic [2:0] PARSER_MOD_ID = 3'd0
) (
	input  logic                    axis_clk,
	input  logic                    aresetn,
	input  logic                    hdr_wr_en,
	input  logic [HDR_W-1:0]        hdr_wr_segs,
	input  logic [AXIS_TUSER_W-1:0] hdr_wr_tuser,
	input  logic                    vlan_wr_en,
	input  logic [VLAN_W-1:0]       vlan_wr_id,
	input  logic                    stg_ready_in,
	input  logic                    out_vlan_ready,
	input  logic [AXIS_DATA_W-1:0]  ctrl_s_tdata,
	input  logic [AXIS_TUSER_W-1:0] ctrl_s_tuser,
	input  logic [AXIS_KEEP_W-1:0]  ctrl_s_tkeep,
	input  logic                    ctrl_s_tvalid,
	input  logic                    ctrl_s_tlast,
	output logic                    hdr_full,
	output logic                    vlan_full,
	output logic                    parser_valid,
	output logic [PHV_W-1:0]        pkt_hdr_vec,
	output logic [VLAN_W-1:0]       out_vlan,
	output logic                    out_vlan_valid,
	output logic [AXIS_DATA_W-1:0]  ctrl_m_tdata,
	output logic [AXIS_TUSER_W-1:0] ctrl_m_tuser,
	output logic [AXIS_KEEP_W-1:0]  ctrl_m_tkeep,
	output logic                    ctrl_m_tvalid,
	output logic                    ctrl_m_tlast
);

logic [HDR_W+AXIS_TUSER_W-1:0] seg_head;
logic [VLAN_W-1:0]             vlan_head;
logic                          segs_empty;
logic                          vlan_empty;
logic                          segs_rd;
logic                          vlan_rd;
logic                          ram_wr_en;
logic [ACT_RAM_AW-1:0]         ram_wr_addr;
logic [ACT_RAM_W-1:0]          ram_wr_data;
logic [ACT_RAM_W-1:0]          act_entry;

// segments on top, first-beat tuser below
parser_fifo #(
	.WIDTH      (HDR_W + AXIS_TUSER_W),
	.DEPTH_LOG2 (4)
) u_seg_fifo (
	.axis_clk (axis_clk),
	.aresetn  (aresetn),
	.wr_en    (hdr_wr_en),
	.wr_data  ({hdr_wr_segs, hdr_wr_tuser}),
	.rd_en    (segs_rd),
	.rd_data  (seg_head),
	.empty    (segs_empty),
	.full     (hdr_full)
);

parser_fifo #(
	.WIDTH      (VLAN_W),
	.DEPTH_LOG2 (4)
) u_vlan_fifo (
	.axis_clk (axis_clk),
	.aresetn  (aresetn),
	.wr_en    (vlan_wr_en),
	.wr_data  (vlan_wr_id),
	.rd_en    (vlan_rd),
	.rd_data  (vlan_head),
	.empty    (vlan_empty),
	.full     (vlan_full)
);

parse_ctrl_writer #(
	.PARSER_MOD_ID (PARSER_MOD_ID)
) u_ctrl_writer (
	.axis_clk      (axis_clk),
	.aresetn       (aresetn),
	.ctrl_s_tdata  (ctrl_s_tdata),
	.ctrl_s_tuser  (ctrl_s_tuser),
	.ctrl_s_tkeep  (ctrl_s_tkeep),
	.ctrl_s_tvalid (ctrl_s_tvalid),
	.ctrl_s_tlast  (ctrl_s_tlast),
	.ctrl_m_tdata  (ctrl_m_tdata),
	.ctrl_m_tuser  (ctrl_m_tuser),
	.ctrl_m_tkeep  (ctrl_m_tkeep),
	.ctrl_m_tvalid (ctrl_m_tvalid),
	.ctrl_m_tlast  (ctrl_m_tlast),
	.ram_wr_en     (ram_wr_en),
	.ram_wr_addr   (ram_wr_addr),
	.ram_wr_data   (ram_wr_data)
);

parse_act_ram u_act_ram (
	.axis_clk (axis_clk),
	.wr_en    (ram_wr_en),
	.wr_addr  (ram_wr_addr),
	.wr_data  (ram_wr_data),
	.rd_addr  (vlan_head[VLAN_SEL_LSB +: ACT_RAM_AW]),
	.rd_data  (act_entry)
);

parser_do_parsing u_do_parsing (
	.axis_clk       (axis_clk),
	.aresetn        (aresetn),
	.hdr_segs       (seg_head[AXIS_TUSER_W +: HDR_W]),
	.tuser_1st      (seg_head[AXIS_TUSER_W-1:0]),
	.vlan_id        (vlan_head),
	.segs_empty     (segs_empty),
	.vlan_empty     (vlan_empty),
	.act_entry      (act_entry),
	.stg_ready_in   (stg_ready_in),
	.out_vlan_ready (out_vlan_ready),
	.segs_rd        (segs_rd),
	.vlan_rd        (vlan_rd),
	.parser_valid   (parser_valid),
	.pkt_hdr_vec    (pkt_hdr_vec),
	.out_vlan       (out_vlan),
	.out_vlan_valid (out_vlan_valid)
);

endmodule

//--- testbench/parser_chk.sv
`timescale 1ns/100ps

module parser_chk (
	input logic axis_clk,
	input logic aresetn,
	input logic parser_valid,
	input logic out_vlan_valid,
	input logic ctrl_s_tvalid,
	input logic ctrl_m_tvalid,
	input logic ctrl_m_tlast
);

logic vlan_seen;

// set by a vlan pulse and cleared when the phv leaves
always_ff @(posedge axis_clk) begin
	if (!aresetn) begin
		vlan_seen <= 1'b0;
	end else if (parser_valid) begin
		vlan_seen <= out_vlan_valid;
	end else if (out_vlan_valid) begin
		vlan_seen <= 1'b1;
	end
end

a_valid_single: assert property (@(posedge axis_clk) disable iff (!aresetn)
	parser_valid |=> !parser_valid)
	else $error("parser_valid high on two consecutive cycles");

a_vlan_once: assert property (@(posedge axis_clk) disable iff (!aresetn)
	out_vlan_valid && !parser_valid |-> !vlan_seen)
	else $error("out_vlan_valid pulsed twice without a parser_valid between");

a_ctrl_fwd: assert property (@(posedge axis_clk) disable iff (!aresetn)
	$past(aresetn) |-> ctrl_m_tvalid == $past(ctrl_s_tvalid))
	else $error("ctrl_m_tvalid does not follow ctrl_s_tvalid");

a_reset_low: assert property (@(posedge axis_clk)
	$rose(aresetn) |-> !ctrl_m_tvalid && !ctrl_m_tlast)
	else $error("control outputs not low after reset");

endmodule

bind pkt_hdr_parser_top parser_chk u_parser_chk (
	.axis_clk       (axis_clk),
	.aresetn        (aresetn),
	.parser_valid   (parser_valid),
	.out_vlan_valid (out_vlan_valid),
	.ctrl_s_tvalid  (ctrl_s_tvalid),
	.ctrl_m_tvalid  (ctrl_m_tvalid),
	.ctrl_m_tlast   (ctrl_m_tlast)
);

//--- testbench/tb_pkt_hdr_parser.sv
`timescale 1ns/100ps

module tb_pkt_hdr_parser
	import parser_pkg::*;
();

localparam logic [2:0] MOD_ID = 3'd3;
localparam int NUM_ROWS = 4;
localparam int NUM_RAND = 8;
localparam int TIMEOUT = 200;

logic                    axis_clk;
logic                    aresetn;
logic                    hdr_wr_en;
logic [HDR_W-1:0]        hdr_wr_segs;
logic [AXIS_TUSER_W-1:0] hdr_wr_tuser;
logic                    vlan_wr_en;
logic [VLAN_W-1:0]       vlan_wr_id;
logic                    stg_ready_in;
logic                    out_vlan_ready;
logic [AXIS_DATA_W-1:0]  ctrl_s_tdata;
logic [AXIS_TUSER_W-1:0] ctrl_s_tuser;
logic [AXIS_KEEP_W-1:0]  ctrl_s_tkeep;
logic                    ctrl_s_tvalid;
logic                    ctrl_s_tlast;
logic                    hdr_full;
logic                    vlan_full;
logic                    parser_valid;
logic [PHV_W-1:0]        pkt_hdr_vec;
logic [VLAN_W-1:0]       out_vlan;
logic                    out_vlan_valid;
logic [AXIS_DATA_W-1:0]  ctrl_m_tdata;
logic [AXIS_TUSER_W-1:0] ctrl_m_tuser;
logic [AXIS_KEEP_W-1:0]  ctrl_m_tkeep;
logic                    ctrl_m_tvalid;
logic                    ctrl_m_tlast;

// stimulus table with the expected phv filled in per row
string                row_name  [NUM_ROWS];
logic [2:0]           row_mod   [NUM_ROWS];
logic [VLAN_W-1:0]    row_vlan  [NUM_ROWS];
logic [ACT_RAM_W-1:0] row_entry [NUM_ROWS];
logic [31:0]          row_seed  [NUM_ROWS];
int                   row_stall [NUM_ROWS];
logic [PHV_W-1:0]     row_exp   [NUM_ROWS];

logic [ACT_RAM_W-1:0]    ram_model [1 << ACT_RAM_AW];
logic [VLAN_W-1:0]       rand_vlan [NUM_RAND];
logic [HDR_W-1:0]        rand_hdr [NUM_RAND];
logic [AXIS_TUSER_W-1:0] rand_tuser [NUM_RAND];
logic [PHV_W-1:0]        rand_exp [NUM_RAND];
logic [PHV_W-1:0]        phv_seen [$];
logic [VLAN_W-1:0]       vlan_seen [$];
int errors;
int tests_run;
int tests_failed;

pkt_hdr_parser_top #(
	.PARSER_MOD_ID (MOD_ID)
) dut (.*);

always #50 axis_clk = ~axis_clk;

// record each phv and vlan pulse
always @(negedge axis_clk) begin
	if (aresetn && parser_valid) begin
		phv_seen.push_back(pkt_hdr_vec);
	end
	if (aresetn && out_vlan_valid) begin
		vlan_seen.push_back(out_vlan);
	end
end

function automatic logic [ACT_W-1:0] make_action(input bit valid, input int typ,
	input int idx, input int off);
	logic [ACT_W-1:0] a;
	a = '0;
	a[ACT_VALID_BIT] = valid;
	a[ACT_IDX_LSB +: ACT_IDX_W] = idx[2:0];
	a[ACT_TYPE_LSB +: ACT_TYPE_W] = typ[1:0];
	a[ACT_OFF_LSB +: ACT_OFF_W] = off[6:0];
	return a;
endfunction

function automatic logic [HDR_W-1:0] fill_header(input logic [31:0] seed);
	logic [HDR_W-1:0] h;
	for (int w = 0; w < HDR_W / 32; w++) begin
		h[32 * w +: 32] = seed ^ (32'h9e37_79b9 * (w + 1));
	end
	return h;
endfunction

task automatic report_error(input string msg);
	$display("CHECK FAILED at %0t ns: %s", $time, msg);
	errors++;
endtask

task automatic abort_run(input string why);
	$display("%s", why);
	$display("Test failures found");
	$finish;
endtask

task automatic end_test(input string name, input int errs_before);
	tests_run++;
	if (errors == errs_before) begin
		$display("test %0d %s: ok", tests_run, name);
	end else begin
		tests_failed++;
		$display("test %0d %s: FAILED", tests_run, name);
	end
endtask

// reference phv where later actions overwrite earlier ones
task automatic expect_phv(input logic [ACT_RAM_W-1:0] entry, input logic [HDR_W-1:0] hdr,
	input logic [AXIS_TUSER_W-1:0] tuser, input logic [VLAN_W-1:0] vlan,
	output logic [PHV_W-1:0] phv);
	logic [ACT_W-1:0] a;
	logic [47:0] field;
	int typ;
	int idx;
	int nbytes;
	int pos;
	phv = '0;
	for (int n = 0; n < NUM_ACTS; n++) begin
		a = entry[ACT_RAM_W - 1 - ACT_W * n -: ACT_W];
		typ = a[ACT_TYPE_LSB +: ACT_TYPE_W];
		idx = a[ACT_IDX_LSB +: ACT_IDX_W];
		nbytes = a[ACT_VALID_BIT] ? 2 * typ : 0;
		field = '0;
		for (int j = 0; j < nbytes; j++) begin
			pos = a[ACT_OFF_LSB +: ACT_OFF_W] + j;
			field = {field[39:0], (pos < HDR_W / 8) ? hdr[8 * pos +: 8] : 8'h00};
		end
		case (nbytes)
			2: phv[PHV_2B_LSB + 16 * idx +: 16] = field[15:0];
			4: phv[PHV_4B_LSB + 32 * idx +: 32] = field[31:0];
			6: phv[PHV_6B_LSB + 48 * idx +: 48] = field;
			default: ;
		endcase
	end
	phv[AXIS_TUSER_W-1:0] = tuser;
	phv[AXIS_TUSER_W + 1 +: VLAN_W] = vlan;
endtask

// four beats each checked on ctrl_m_ one cycle later
task automatic send_ctrl_packet(input logic [2:0] mod, input logic [4:0] addr,
	input logic [ACT_RAM_W-1:0] entry);
	logic [AXIS_DATA_W-1:0]  beat [4];
	logic [AXIS_TUSER_W-1:0] user [4];
	logic [AXIS_KEEP_W-1:0]  keep [4];
	for (int b = 0; b < 4; b++) begin
		for (int w = 0; w < AXIS_DATA_W / 32; w++) begin
			beat[b][32 * w +: 32] = $urandom;
		end
		user[b] = {$urandom, $urandom, $urandom, $urandom};
		keep[b] = $urandom;
	end
	beat[1][CTRL_MODID_LSB +: 8] = {5'b0, mod};
	beat[1][CTRL_ADDR_LSB +: 8] = {3'b0, addr};
	for (int k = 0; k < ACT_RAM_W / 8; k++) begin
		beat[2][8 * k +: 8] = entry[ACT_RAM_W - 1 - 8 * k -: 8];
	end
	for (int b = 0; b <= 4; b++) begin
		@(negedge axis_clk);
		if (b > 0) begin
			assert (ctrl_m_tvalid && ctrl_m_tdata == beat[b-1] && ctrl_m_tuser == user[b-1]
				&& ctrl_m_tkeep == keep[b-1] && ctrl_m_tlast == (b == 4))
			else report_error($sformatf("control beat %0d not forwarded unchanged", b - 1));
		end
		if (b < 4) begin
			ctrl_s_tdata = beat[b];
			ctrl_s_tuser = user[b];
			ctrl_s_tkeep = keep[b];
			ctrl_s_tvalid = 1'b1;
			ctrl_s_tlast = (b == 3);
		end else begin
			ctrl_s_tkeep = '0;
			ctrl_s_tvalid = 1'b0;
			ctrl_s_tlast = 1'b0;
		end
	end
	if (mod == MOD_ID) begin
		ram_model[addr] = entry;
	end
endtask

task automatic push_packet(input logic [HDR_W-1:0] hdr, input logic [AXIS_TUSER_W-1:0] tuser,
	input logic [VLAN_W-1:0] vlan);
	@(negedge axis_clk);
	assert (!hdr_full && !vlan_full) else report_error("input FIFO full before a push");
	hdr_wr_en = 1'b1;
	hdr_wr_segs = hdr;
	hdr_wr_tuser = tuser;
	vlan_wr_en = 1'b1;
	vlan_wr_id = vlan;
	@(negedge axis_clk);
	hdr_wr_en = 1'b0;
	vlan_wr_en = 1'b0;
endtask

task automatic wait_for_events(input int n_phv, input int n_vlan, input string what);
	int cycles;
	cycles = 0;
	while ((phv_seen.size() < n_phv || vlan_seen.size() < n_vlan) && cycles < TIMEOUT) begin
		@(posedge axis_clk);
		cycles++;
	end
	if (phv_seen.size() < n_phv || vlan_seen.size() < n_vlan) begin
		abort_run({"timed out waiting for ", what});
	end
endtask

task automatic load_table();
	row_name[0] = "table write and lookup";
	row_mod[0] = MOD_ID;
	row_vlan[0] = 12'h0a5;
	row_seed[0] = 32'h1357_9bdf;
	row_stall[0] = 0;
	row_entry[0] = {make_action(1, 1, 0, 12), make_action(1, 2, 1, 26),
		make_action(1, 3, 0, 0), make_action(1, 3, 1, 6), make_action(1, 1, 0, 20),
		make_action(0, 2, 2, 30), make_action(1, 3, 7, 125), make_action(1, 2, 7, 127),
		make_action(1, 1, 3, 127), make_action(1, 0, 5, 40)};
	// same vlan and header as row 0 but another module id
	row_name[1] = "module filter";
	row_mod[1] = 3'd5;
	row_vlan[1] = 12'h0a5;
	row_seed[1] = 32'h1357_9bdf;
	row_stall[1] = 0;
	for (int k = 0; k < NUM_ACTS; k++) begin
		row_entry[1][ACT_RAM_W - 1 - ACT_W * k -: ACT_W] = make_action(1, 1, k, 3 * k);
	end
	row_name[2] = "back-pressure";
	row_mod[2] = MOD_ID;
	row_vlan[2] = 12'h1f0;
	row_seed[2] = 32'h2468_ace0;
	row_stall[2] = 20;
	row_entry[2] = {make_action(1, 2, 4, 40), make_action(1, 2, 4, 44),
		make_action(1, 3, 5, 100), make_action(1, 1, 7, 126), make_action(0, 3, 2, 0),
		make_action(1, 1, 6, 64), make_action(1, 3, 5, 122), make_action(0, 1, 1, 1),
		make_action(1, 2, 0, 124), make_action(1, 1, 6, 2)};
	row_name[3] = "invalid actions";
	row_mod[3] = MOD_ID;
	row_vlan[3] = 12'h804;
	row_seed[3] = 32'h0f0f_5a5a;
	row_stall[3] = 0;
	for (int k = 0; k < NUM_ACTS; k++) begin
		row_entry[3][ACT_RAM_W - 1 - ACT_W * k -: ACT_W] = make_action(0, k % 3 + 1, k, 10 * k);
	end
endtask

initial begin
	logic [HDR_W-1:0]        hdr;
	logic [AXIS_TUSER_W-1:0] tuser;
	logic [ACT_RAM_W-1:0]    entry;
	int base_phv;
	int base_vlan;
	int errs_before;
	void'($urandom(32'hc1f7_5130));
	errors = 0;
	tests_run = 0;
	tests_failed = 0;
	axis_clk = 1'b0;
	aresetn = 1'b0;
	hdr_wr_en = 1'b0;
	hdr_wr_segs = '0;
	hdr_wr_tuser = '0;
	vlan_wr_en = 1'b0;
	vlan_wr_id = '0;
	stg_ready_in = 1'b0;
	out_vlan_ready = 1'b1;
	ctrl_s_tdata = '0;
	ctrl_s_tuser = '0;
	ctrl_s_tkeep = '0;
	ctrl_s_tvalid = 1'b0;
	ctrl_s_tlast = 1'b0;
	load_table();
	repeat (16) @(posedge axis_clk);
	@(negedge axis_clk);
	aresetn = 1'b1;

	for (int r = 0; r < NUM_ROWS; r++) begin
		errs_before = errors;
		base_phv = phv_seen.size();
		base_vlan = vlan_seen.size();
		send_ctrl_packet(row_mod[r], row_vlan[r][VLAN_SEL_LSB +: ACT_RAM_AW], row_entry[r]);
		hdr = fill_header(row_seed[r]);
		tuser = {row_seed[r], ~row_seed[r], row_seed[r] ^ 32'hffff_0000, row_seed[r] + 1};
		expect_phv(ram_model[row_vlan[r][VLAN_SEL_LSB +: ACT_RAM_AW]], hdr, tuser, row_vlan[r],
			row_exp[r]);
		stg_ready_in = (row_stall[r] == 0);
		push_packet(hdr, tuser, row_vlan[r]);
		if (row_stall[r] > 0) begin
			repeat (row_stall[r]) @(posedge axis_clk);
			assert (phv_seen.size() == base_phv)
			else report_error("parser_valid while stg_ready_in low");
			@(negedge axis_clk);
			stg_ready_in = 1'b1;
		end
		wait_for_events(base_phv + 1, base_vlan + 1, "parser_valid and out_vlan_valid");
		repeat (8) @(posedge axis_clk);
		assert (phv_seen.size() == base_phv + 1) else report_error("extra parser_valid pulse");
		assert (vlan_seen.size() == base_vlan + 1) else report_error("extra out_vlan_valid");
		assert (phv_seen[base_phv] == row_exp[r])
		else report_error($sformatf("row %0d PHV mismatch", r));
		assert (vlan_seen[base_vlan] == row_vlan[r])
		else report_error($sformatf("row %0d out_vlan %h", r, vlan_seen[base_vlan]));
		end_test(row_name[r], errs_before);
	end

	// random entries first and then eight packets queued under back-pressure
	@(negedge axis_clk);
	stg_ready_in = 1'b0;
	for (int p = 0; p < NUM_RAND; p++) begin
		rand_vlan[p] = $urandom;
		for (int w = 0; w < ACT_RAM_W / 32; w++) begin
			entry[32 * w +: 32] = $urandom;
		end
		send_ctrl_packet(MOD_ID, rand_vlan[p][VLAN_SEL_LSB +: ACT_RAM_AW], entry);
	end
	base_phv = phv_seen.size();
	base_vlan = vlan_seen.size();
	for (int p = 0; p < NUM_RAND; p++) begin
		for (int w = 0; w < HDR_W / 32; w++) begin
			rand_hdr[p][32 * w +: 32] = $urandom;
		end
		rand_tuser[p] = {$urandom, $urandom, $urandom, $urandom};
		push_packet(rand_hdr[p], rand_tuser[p], rand_vlan[p]);
	end
	for (int p = 0; p < NUM_RAND; p++) begin
		expect_phv(ram_model[rand_vlan[p][VLAN_SEL_LSB +: ACT_RAM_AW]], rand_hdr[p],
			rand_tuser[p], rand_vlan[p], rand_exp[p]);
	end
	@(negedge axis_clk);
	stg_ready_in = 1'b1;
	wait_for_events(base_phv + NUM_RAND, base_vlan + NUM_RAND, "back-to-back PHVs");
	repeat (8) @(posedge axis_clk);
	for (int p = 0; p < NUM_RAND; p++) begin
		errs_before = errors;
		assert (phv_seen[base_phv + p] == rand_exp[p])
		else report_error($sformatf("random packet %0d PHV mismatch", p));
		assert (vlan_seen[base_vlan + p] == rand_vlan[p])
		else report_error($sformatf("random packet %0d out_vlan mismatch", p));
		end_test($sformatf("back-to-back packet %0d", p), errs_before);
	end
	assert (phv_seen.size() == base_phv + NUM_RAND) else report_error("extra PHVs after burst");

	$display("tests run %0d, tests failed %0d, checks failed %0d", tests_run, tests_failed,
		errors);
	if (errors == 0) begin
		$display("All tests passed!");
	end else begin
		$display("Test failures found");
	end
	$finish;
end

endmodule

//--- flist.f
hw/parser_pkg.sv
hw/parser_fifo.sv
hw/parse_act_ram.sv
hw/sub_parser.sv
hw/parse_ctrl_writer.sv
hw/parser_do_parsing.sv
hw/pkt_hdr_parser_top.sv
testbench/parser_chk.sv
testbench/tb_pkt_hdr_parser.sv
